//--- Bender.yml
package:
  name: idct_engine

sources:
  - files:
      - rtl/block_pkg.sv
      - rtl/idct_math_pkg.sv
      - rtl/buf_if.sv
      - rtl/block_buffer.sv
      - rtl/coeff_receiver.sv
      - rtl/idct_mac_engine.sv
      - rtl/pixel_sender.sv
      - rtl/idct_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/idct_props.sv
      - dv/idct_tb.sv

//--- dv/idct_props.sv
`timescale 1ns/1ps

module idct_props (
	input logic             CLOCK_50_I,
	input logic             resetn,
	input logic             in_req,
	input logic             in_ack,
	input logic             out_req,
	input logic             out_ack,
	input block_pkg::coef_t out_data
);

////////////////////////////////////////
// Four-phase handshake rules
////////////////////////////////////////

// Sample held until the sink has taken it
out_data_stable: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
	(out_req && !out_ack) |=> $stable(out_data))
	else $error("out_data changed while waiting for out_ack");

in_ack_falls_late: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
	$fell(in_ack) |-> !$past(in_req))
	else $error("in_ack fell while in_req was still high");

in_ack_rises_on_req: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
	$rose(in_ack) |-> $past(in_req))
	else $error("in_ack rose without in_req");

out_req_falls_late: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
	$fell(out_req) |-> $past(out_ack))
	else $error("out_req fell before out_ack was high");

endmodule

bind idct_top idct_props u_idct_props (
	.CLOCK_50_I (CLOCK_50_I),
	.resetn     (resetn),
	.in_req     (in_req),
	.in_ack     (in_ack),
	.out_req    (out_req),
	.out_ack    (out_ack),
	.out_data   (out_data)
);

//--- dv/idct_model.svh
`ifndef IDCT_MODEL_SVH
`define IDCT_MODEL_SVH

// Reference IDCT of one block, T = S'.C then S = Ct.T
// Each product keeps its low 32 bits and is shifted before the sum
task automatic idct_reference(
	input  block_pkg::coef_t coefs [block_pkg::BLOCK_SIZE],
	input  int               shift1,
	input  int               shift2,
	output block_pkg::coef_t samples [block_pkg::BLOCK_SIZE]
);
	idct_math_pkg::acc_t  t_mat [block_pkg::BLOCK_SIZE];
	idct_math_pkg::acc_t  sum;
	idct_math_pkg::prod_t prod;
	logic signed [63:0]   full;

	// Pass 1, row i of S' against column j of C
	for (int i = 0; i < block_pkg::BLOCK_DIM; i++) begin
		for (int j = 0; j < block_pkg::BLOCK_DIM; j++) begin
			sum = '0;
			for (int k = 0; k < block_pkg::BLOCK_DIM; k++) begin
				full = longint'(coefs[i * block_pkg::BLOCK_DIM + k])
				       * longint'(idct_math_pkg::C_TABLE[k][j]);
				prod = full[31:0];
				sum  = sum + (prod >>> shift1);
			end
			t_mat[i * block_pkg::BLOCK_DIM + j] = sum;
		end
	end

	// Pass 2, column i of C against column j of T
	for (int i = 0; i < block_pkg::BLOCK_DIM; i++) begin
		for (int j = 0; j < block_pkg::BLOCK_DIM; j++) begin
			sum = '0;
			for (int k = 0; k < block_pkg::BLOCK_DIM; k++) begin
				full = longint'(idct_math_pkg::C_TABLE[k][i])
				       * longint'(t_mat[k * block_pkg::BLOCK_DIM + j]);
				prod = full[31:0];  // Truncated product
				sum  = sum + (prod >>> shift2);
			end
			samples[i * block_pkg::BLOCK_DIM + j] = sum[15:0];  // Low 16 bits only
		end
	end
endtask

`endif

//--- dv/idct_tb.sv
`timescale 1ns/1ps

module idct_tb;

localparam int PASS1_SHIFT      = idct_math_pkg::PASS1_SHIFT_DEF;
localparam int PASS2_SHIFT      = idct_math_pkg::PASS2_SHIFT_DEF;
localparam int RUN_BLOCKS       = 8;                      // Blocks per burst
localparam int TOTAL_BLOCKS     = 2 + 3 * RUN_BLOCKS;
localparam int CYCLES_PER_BLOCK = 3000;
localparam int TIMEOUT_CYCLES   = TOTAL_BLOCKS * CYCLES_PER_BLOCK;
localparam logic [31:0] SEED    = 32'h328a_b416;

logic             CLOCK_50_I;
logic             resetn;
logic             in_req;
block_pkg::coef_t in_data;
logic             in_ack;
logic             out_req;
block_pkg::coef_t out_data;
logic             out_ack;

block_pkg::coef_t expected_q [$];
block_pkg::coef_t saved_coefs [RUN_BLOCKS * block_pkg::BLOCK_SIZE];

logic [31:0] in_rng  = SEED;                  // Coefficients and input gaps
logic [31:0] out_rng = SEED ^ 32'h9e37_79b9;  // out_ack delays
int          sent_blocks   = 0;
int          recv_count    = 0;
int          ack_max_delay = 0;
int          cycle_count   = 0;

`include "idct_model.svh"

idct_top #(
	.PASS1_SHIFT (PASS1_SHIFT),
	.PASS2_SHIFT (PASS2_SHIFT)
) u_idct_top (
	.CLOCK_50_I (CLOCK_50_I),
	.resetn     (resetn),
	.in_req     (in_req),
	.in_data    (in_data),
	.in_ack     (in_ack),
	.out_req    (out_req),
	.out_data   (out_data),
	.out_ack    (out_ack)
);

initial begin
	CLOCK_50_I = 1'b0;
	forever #10 CLOCK_50_I = ~CLOCK_50_I;
end

always @(posedge CLOCK_50_I) cycle_count <= cycle_count + 1;

////////////////////////////////////////
// Helpers
////////////////////////////////////////

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// Uniform in -1023 to 1023
function automatic block_pkg::coef_t draw_coef();
	in_rng = xorshift32(in_rng);
	return block_pkg::coef_t'(int'(in_rng % 2047) - 1023);
endfunction

task automatic next_cycle();
	@(posedge CLOCK_50_I);
	#2;  // Drive and sample just after the edge
endtask

task automatic compare(input logic signed [31:0] actual, input logic signed [31:0] expected,
                       input string what);
	if (actual !== expected) begin
		$display("Error at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
		$display("Something failed");
		$fatal(1, "Stopping on the first error");
	end
endtask

task automatic send_word(input block_pkg::coef_t data, input int gap);
	repeat (gap) next_cycle();
	in_data = data;
	in_req  = 1'b1;
	do next_cycle(); while (!in_ack);
	in_req = 1'b0;
	do next_cycle(); while (in_ack);
endtask

// Queue the expected samples first, then feed the block
task automatic send_block(input block_pkg::coef_t blk [block_pkg::BLOCK_SIZE],
                          input int max_gap);
	block_pkg::coef_t expected [block_pkg::BLOCK_SIZE];
	int gap;
	idct_reference(blk, PASS1_SHIFT, PASS2_SHIFT, expected);
	foreach (expected[n]) expected_q.push_back(expected[n]);
	foreach (blk[n]) begin
		in_rng = xorshift32(in_rng);
		gap    = in_rng % (max_gap + 1);
		send_word(blk[n], gap);
	end
	sent_blocks++;
endtask

task automatic replay_saved(input int max_gap);
	block_pkg::coef_t blk [block_pkg::BLOCK_SIZE];
	for (int b = 0; b < RUN_BLOCKS; b++) begin
		foreach (blk[n]) blk[n] = saved_coefs[b * block_pkg::BLOCK_SIZE + n];
		send_block(blk, max_gap);
	end
endtask

task automatic wait_for_outputs();
	wait (recv_count == sent_blocks * block_pkg::BLOCK_SIZE);
	next_cycle();
endtask

////////////////////////////////////////
// Output sink and checker
////////////////////////////////////////

initial begin : output_side
	block_pkg::coef_t exp_sample;
	int               delay;
	wait (resetn === 1'b1);
	forever begin
		next_cycle();
		if (out_req) begin
			if (expected_q.size() == 0) begin
				$display("An output sample arrived with no expected sample left at %0t ns", $time);
				$display("Something failed");
				$fatal(1, "Extra output sample");
			end else begin
				exp_sample = expected_q.pop_front();
				compare(out_data, exp_sample,
				        $sformatf("block %0d sample %0d", recv_count / block_pkg::BLOCK_SIZE,
				                  recv_count % block_pkg::BLOCK_SIZE));
				recv_count++;
				out_rng = xorshift32(out_rng);
				delay   = out_rng % (ack_max_delay + 1);
				repeat (delay) next_cycle();  // Slow sink
				out_ack = 1'b1;
				do next_cycle(); while (out_req);
				out_ack = 1'b0;
			end
		end
	end
end

////////////////////////////////////////
// Test sequence
////////////////////////////////////////

initial begin : main_sequence
	block_pkg::coef_t blk [block_pkg::BLOCK_SIZE];
	in_req  = 1'b0;
	in_data = '0;
	out_ack = 1'b0;
	resetn  = 1'b0;
	repeat (2) @(posedge CLOCK_50_I);
	#2 resetn = 1'b1;

	compare(in_ack, 0, "in_ack after reset");
	compare(out_req, 0, "out_req after reset");
	repeat (4) next_cycle();
	compare(in_ack, 0, "in_ack while idle");
	compare(out_req, 0, "out_req while idle");

	foreach (blk[n]) blk[n] = '0;   // All-zero block
	send_block(blk, 0);
	wait_for_outputs();

	foreach (blk[n]) blk[n] = draw_coef();
	send_block(blk, 0);
	wait_for_outputs();

	// Burst with no pauses, then the same burst against a slow sink
	foreach (saved_coefs[n]) saved_coefs[n] = draw_coef();
	replay_saved(0);
	wait_for_outputs();
	ack_max_delay = 5;
	replay_saved(0);
	wait_for_outputs();

	replay_saved(5);   // Random input gaps
	wait_for_outputs();

	repeat (200) next_cycle();  // Quiet tail where a stray extra sample would show up
	$display("Everything OK");
	$finish;
end

initial begin : watchdog
	wait (cycle_count >= TIMEOUT_CYCLES);
	$display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
	$display("Something failed");
	$fatal(1, "Timeout");
end

endmodule

//--- rtl/block_buffer.sv
`timescale 1ns/1ps

module block_buffer #(
	parameter type payload_t = block_pkg::coef_t
) (
	input logic   CLOCK_50_I,
	buf_if.memory bus
);

////////////////////////////////////////
// Storage
////////////////////////////////////////

// One full block in row-major order
payload_t mem [block_pkg::BLOCK_SIZE];

// Synchronous write
always_ff @(posedge CLOCK_50_I) begin
	if (bus.wr_en) begin
		mem[bus.wr_addr] <= bus.wr_data;
	end
end

// Registered read, one cycle of latency
always_ff @(posedge CLOCK_50_I) begin
	bus.rd_data <= mem[bus.rd_addr];
end

endmodule

//--- rtl/block_pkg.sv
package block_pkg;

	////////////////////////////////////////
	// Block geometry
	////////////////////////////////////////

	parameter int BLOCK_DIM  = 8;                      // Side of one block
	parameter int BLOCK_SIZE = BLOCK_DIM * BLOCK_DIM;  // Entries per block

	parameter int ADDR_W = $clog2(BLOCK_SIZE);
	parameter int IDX_W  = $clog2(BLOCK_DIM);

	////////////////////////////////////////
	// Buffer address and sample types
	////////////////////////////////////////

	// Row-major address, row in the upper bits
	typedef logic [ADDR_W-1:0] addr_t;

	typedef logic [IDX_W-1:0] dim_idx_t; // Row, column or term index

	// Pre-IDCT coefficient on the way in, sample on the way out
	typedef logic signed [15:0] coef_t;

endpackage

//--- rtl/buf_if.sv
`timescale 1ns/1ps

// One write port and one registered read port of a block buffer
interface buf_if #(
	parameter type payload_t = block_pkg::coef_t
) ();

	logic              wr_en;
	block_pkg::addr_t  wr_addr;
	payload_t          wr_data;

	block_pkg::addr_t  rd_addr;
	payload_t          rd_data;   // Valid one cycle after rd_addr

	modport writer (output wr_en, output wr_addr, output wr_data);

	modport reader (output rd_addr, input rd_data);

	modport memory (
		input  wr_en,
		input  wr_addr,
		input  wr_data,
		input  rd_addr,
		output rd_data
	);

endinterface

//--- rtl/coeff_receiver.sv
`timescale 1ns/1ps

module coeff_receiver (
	input  logic             CLOCK_50_I,
	input  logic             resetn,

	input  logic             in_req,
	input  block_pkg::coef_t in_data,
	output logic             in_ack,

	output logic             blk_req,
	input  logic             blk_ack,

	buf_if.writer            coef_wr
);

localparam block_pkg::addr_t LAST_ADDR = block_pkg::addr_t'(block_pkg::BLOCK_SIZE - 1);

block_pkg::addr_t wr_ptr;  // Next free entry
logic             accept;

// A word is taken only while the store is free and the last exchange has closed
assign accept = in_req && !in_ack && !blk_req && !blk_ack;

assign coef_wr.wr_en   = accept;
assign coef_wr.wr_addr = wr_ptr;
assign coef_wr.wr_data = in_data;   // Held stable by the source while in_req is high

////////////////////////////////////////
// Input handshake and fill counter
////////////////////////////////////////

always_ff @(posedge CLOCK_50_I or negedge resetn) begin
	if (!resetn) begin
		in_ack  <= 1'b0;
		blk_req <= 1'b0;
		wr_ptr  <= '0;
	end else begin
		if (accept) begin
			in_ack <= 1'b1;            // Word is stored at this edge
			wr_ptr <= wr_ptr + 1'b1;   // Wraps to 0 after the last entry
			if (wr_ptr == LAST_ADDR) begin
				blk_req <= 1'b1;       // Full block ready for the engine
			end
		end else if (in_ack && !in_req) begin
			in_ack <= 1'b0;
		end

		// Engine has read the block, the store may be refilled
		if (blk_req && blk_ack) begin
			blk_req <= 1'b0;
		end
	end
end

endmodule

//--- rtl/idct_mac_engine.sv
`timescale 1ns/1ps

module idct_mac_engine #(
	parameter int PASS1_SHIFT = idct_math_pkg::PASS1_SHIFT_DEF,
	parameter int PASS2_SHIFT = idct_math_pkg::PASS2_SHIFT_DEF
) (
	input  logic  CLOCK_50_I,
	input  logic  resetn,

	input  logic  blk_req,
	output logic  blk_ack,
	output logic  res_req,
	input  logic  res_ack,

	buf_if.reader coef_rd,  // S'
	buf_if.writer t_wr,
	buf_if.reader t_rd,
	buf_if.writer s_wr
);

// Term 0 is the read lead-in, terms 1 to 8 accumulate, the last term writes
localparam logic [3:0] TERM_LAST = 4'(block_pkg::BLOCK_DIM + 1);
localparam block_pkg::dim_idx_t LAST_IDX = block_pkg::dim_idx_t'(block_pkg::BLOCK_DIM - 1);

typedef enum logic [2:0] {
	S_IDLE,
	S_PASS1,
	S_BLK_ACK,
	S_WAIT_RES,
	S_PASS2
} engine_state_t;

engine_state_t        state;
block_pkg::dim_idx_t  row;
block_pkg::dim_idx_t  col;
logic [3:0]           term;
block_pkg::dim_idx_t  cos_k;

logic                 pass2;
logic                 last_term;
logic                 last_entry;
logic                 mac_phase;

idct_math_pkg::acc_t  op_a;
idct_math_pkg::cos_t  op_c;
logic signed [47:0]   mult_full;
idct_math_pkg::prod_t prod;
idct_math_pkg::acc_t  prod_sh;
idct_math_pkg::acc_t  acc;

assign pass2      = (state == S_PASS2);
assign last_term  = (term == TERM_LAST);
assign last_entry = (row == LAST_IDX) && (col == LAST_IDX);
assign mac_phase  = (term != 4'd0) && !last_term;

////////////////////////////////////////
// Read addresses and MAC datapath
////////////////////////////////////////

assign coef_rd.rd_addr = {row, term[2:0]};  // S'[row][k]
assign t_rd.rd_addr    = {term[2:0], col};  // T[k][col]

// Table index trails the read address by the read latency
assign cos_k = block_pkg::dim_idx_t'(term - 4'd1);

assign op_a = pass2 ? t_rd.rd_data : idct_math_pkg::acc_t'(coef_rd.rd_data);
assign op_c = pass2 ? idct_math_pkg::C_TABLE[cos_k][row]   // Column row of C, i.e. Ct
                    : idct_math_pkg::C_TABLE[cos_k][col];

assign mult_full = op_a * op_c;
assign prod      = mult_full[31:0];   // Truncated to 32 bits
assign prod_sh   = pass2 ? (prod >>> PASS2_SHIFT) : (prod >>> PASS1_SHIFT);

always_ff @(posedge CLOCK_50_I) begin
	if (term == 4'd0) begin
		acc <= '0;
	end else if (mac_phase) begin
		acc <= acc + prod_sh;
	end
end

// Result of one entry is written on the last term
assign t_wr.wr_en   = (state == S_PASS1) && last_term;
assign t_wr.wr_addr = {row, col};
assign t_wr.wr_data = acc;

assign s_wr.wr_en   = pass2 && last_term;
assign s_wr.wr_addr = {row, col};
assign s_wr.wr_data = block_pkg::coef_t'(acc[15:0]);  // Low 16 bits are the sample

////////////////////////////////////////
// Control FSM
////////////////////////////////////////

always_ff @(posedge CLOCK_50_I or negedge resetn) begin
	if (!resetn) begin
		state   <= S_IDLE;
		row     <= '0;
		col     <= '0;
		term    <= '0;
		blk_ack <= 1'b0;
		res_req <= 1'b0;
	end else begin
		if (res_ack) begin
			res_req <= 1'b0;   // Sender has finished with S
		end

		case (state)
		S_IDLE: begin
			if (blk_req) begin
				state <= S_PASS1;
			end
		end
		S_PASS1, S_PASS2: begin
			if (last_term) begin
				term <= '0;
				col  <= col + 1'b1;   // Row-major walk, both indices wrap
				if (col == LAST_IDX) begin
					row <= row + 1'b1;
				end
				if (last_entry) begin
					if (pass2) begin
						res_req <= 1'b1;
						state   <= S_IDLE;
					end else begin
						blk_ack <= 1'b1;   // S' no longer needed
						state   <= S_BLK_ACK;
					end
				end
			end else begin
				term <= term + 1'b1;
			end
		end
		S_BLK_ACK: begin
			if (!blk_req) begin
				blk_ack <= 1'b0;
				state   <= S_WAIT_RES;
			end
		end
		S_WAIT_RES: begin
			// S buffer still owned by the sender until its exchange closes
			if (!res_req && !res_ack) begin
				state <= S_PASS2;
			end
		end
		default: state <= S_IDLE;
		endcase
	end
end

endmodule

//--- rtl/idct_math_pkg.sv
package idct_math_pkg;

	typedef logic signed [15:0] cos_t;   // Cosine table entry, scaled by 4096/2
	typedef logic signed [31:0] prod_t;  // Low 32 bits of a product
	typedef logic signed [31:0] acc_t;   // Running sum, also a T entry

	// Arithmetic right shift applied to each product before it is summed
	parameter int PASS1_SHIFT_DEF = 8;
	parameter int PASS2_SHIFT_DEF = 16;

	////////////////////////////////////////
	// Cosine table, indexed [k][j]
	////////////////////////////////////////

	// Row k is frequency k, column j is the sample position
	parameter cos_t C_TABLE [8][8] = '{
		'{16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448,
		  16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448},
		'{16'sd2008, 16'sd1702, 16'sd1137, 16'sd399,
		  -16'sd399, -16'sd1137, -16'sd1702, -16'sd2008},
		'{16'sd1892, 16'sd783, -16'sd783, -16'sd1892,
		  -16'sd1892, -16'sd783, 16'sd783, 16'sd1892},
		'{16'sd1702, -16'sd399, -16'sd2008, -16'sd1137,
		  16'sd1137, 16'sd2008, 16'sd399, -16'sd1702},
		'{16'sd1448, -16'sd1448, -16'sd1448, 16'sd1448,
		  16'sd1448, -16'sd1448, -16'sd1448, 16'sd1448},
		'{16'sd1137, -16'sd2008, 16'sd399, 16'sd1702,
		  -16'sd1702, -16'sd399, 16'sd2008, -16'sd1137},
		'{16'sd783, -16'sd1892, 16'sd1892, -16'sd783,
		  -16'sd783, 16'sd1892, -16'sd1892, 16'sd783},
		'{16'sd399, -16'sd1137, 16'sd1702, -16'sd2008,
		  16'sd2008, -16'sd1702, 16'sd1137, -16'sd399}
	};

endpackage

//--- rtl/idct_top.sv
`timescale 1ns/1ps

module idct_top #(
	parameter int PASS1_SHIFT = idct_math_pkg::PASS1_SHIFT_DEF,
	parameter int PASS2_SHIFT = idct_math_pkg::PASS2_SHIFT_DEF
) (
	input  logic             CLOCK_50_I,
	input  logic             resetn,

	input  logic             in_req,
	input  block_pkg::coef_t in_data,
	output logic             in_ack,

	output logic             out_req,
	output block_pkg::coef_t out_data,
	input  logic             out_ack
);

logic blk_req;  // Receiver to engine
logic blk_ack;
logic res_req;  // Engine to sender
logic res_ack;

buf_if #(.payload_t(block_pkg::coef_t))    coef_bus ();
buf_if #(.payload_t(idct_math_pkg::acc_t)) t_bus ();
buf_if #(.payload_t(block_pkg::coef_t))    s_bus ();

////////////////////////////////////////
// Stages
////////////////////////////////////////

coeff_receiver u_coeff_receiver (
	.CLOCK_50_I (CLOCK_50_I),
	.resetn     (resetn),
	.in_req     (in_req),
	.in_data    (in_data),
	.in_ack     (in_ack),
	.blk_req    (blk_req),
	.blk_ack    (blk_ack),
	.coef_wr    (coef_bus.writer)
);

idct_mac_engine #(
	.PASS1_SHIFT (PASS1_SHIFT),
	.PASS2_SHIFT (PASS2_SHIFT)
) u_idct_mac_engine (
	.CLOCK_50_I (CLOCK_50_I),
	.resetn     (resetn),
	.blk_req    (blk_req),
	.blk_ack    (blk_ack),
	.res_req    (res_req),
	.res_ack    (res_ack),
	.coef_rd    (coef_bus.reader),
	.t_wr       (t_bus.writer),
	.t_rd       (t_bus.reader),
	.s_wr       (s_bus.writer)
);

pixel_sender u_pixel_sender (
	.CLOCK_50_I (CLOCK_50_I),
	.resetn     (resetn),
	.res_req    (res_req),
	.res_ack    (res_ack),
	.out_req    (out_req),
	.out_data   (out_data),
	.out_ack    (out_ack),
	.s_rd       (s_bus.reader)
);

////////////////////////////////////////
// Block buffers
////////////////////////////////////////

block_buffer #(.payload_t(block_pkg::coef_t)) u_coef_buf (
	.CLOCK_50_I (CLOCK_50_I),
	.bus        (coef_bus.memory)
);

block_buffer #(.payload_t(idct_math_pkg::acc_t)) u_t_buf (
	.CLOCK_50_I (CLOCK_50_I),
	.bus        (t_bus.memory)
);

block_buffer #(.payload_t(block_pkg::coef_t)) u_s_buf (
	.CLOCK_50_I (CLOCK_50_I),
	.bus        (s_bus.memory)
);

endmodule

//--- rtl/pixel_sender.sv
`timescale 1ns/1ps

module pixel_sender (
	input  logic             CLOCK_50_I,
	input  logic             resetn,

	input  logic             res_req,
	output logic             res_ack,

	output logic             out_req,
	output block_pkg::coef_t out_data,
	input  logic             out_ack,

	buf_if.reader            s_rd
);

localparam block_pkg::addr_t LAST_ADDR = block_pkg::addr_t'(block_pkg::BLOCK_SIZE - 1);

typedef enum logic [2:0] {
	S_IDLE,
	S_READ,
	S_LOAD,
	S_WAIT_ACK,
	S_WAIT_REL,
	S_DONE
} sender_state_t;

sender_state_t    state;
block_pkg::addr_t rd_ptr;

assign s_rd.rd_addr = rd_ptr;

// Sample is held from the rise of out_req to the next load
always_ff @(posedge CLOCK_50_I) begin
	if (state == S_LOAD) begin
		out_data <= s_rd.rd_data;
	end
end

////////////////////////////////////////
// Output handshake FSM
////////////////////////////////////////

always_ff @(posedge CLOCK_50_I or negedge resetn) begin
	if (!resetn) begin
		state   <= S_IDLE;
		rd_ptr  <= '0;
		out_req <= 1'b0;
		res_ack <= 1'b0;
	end else begin
		case (state)
		S_IDLE: begin
			if (res_req) begin
				rd_ptr <= '0;
				state  <= S_READ;
			end
		end
		S_READ: state <= S_LOAD;   // Read in flight
		S_LOAD: begin
			out_req <= 1'b1;
			state   <= S_WAIT_ACK;
		end
		S_WAIT_ACK: begin
			if (out_ack) begin
				out_req <= 1'b0;
				state   <= S_WAIT_REL;
			end
		end
		S_WAIT_REL: begin
			if (!out_ack) begin
				if (rd_ptr == LAST_ADDR) begin
					res_ack <= 1'b1;   // Whole block sent
					state   <= S_DONE;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
					state  <= S_READ;
				end
			end
		end
		S_DONE: begin
			if (!res_req) begin
				res_ack <= 1'b0;
				state   <= S_IDLE;
			end
		end
		default: state <= S_IDLE;
		endcase
	end
end

endmodule

//--- vlog.f
+incdir+dv
rtl/block_pkg.sv
rtl/idct_math_pkg.sv
rtl/buf_if.sv
rtl/block_buffer.sv
rtl/coeff_receiver.sv
rtl/idct_mac_engine.sv
rtl/pixel_sender.sv
rtl/idct_top.sv
dv/idct_props.sv
dv/idct_tb.sv
